// ==== bus_arbiter.sv ====
// Round-robin weight bus arbiter

`timescale 1ns/1ps

module bus_arbiter (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 host_req_i,
    input  logic                 host_we_i,
    input  ising_pkg::spin_idx_t host_s_addr_i,
    input  ising_pkg::spin_idx_t host_d_addr_i,
    input  ising_pkg::weight_t   host_wdata_i,
    input  logic                 sweep_req_i,
    input  logic                 sweep_we_i,
    input  ising_pkg::spin_idx_t sweep_s_addr_i,
    input  ising_pkg::spin_idx_t sweep_d_addr_i,
    input  ising_pkg::weight_t   sweep_wdata_i,
    output logic                 host_gnt_o,
    output logic                 sweep_gnt_o,
    output logic                 bus_we_o,
    output logic                 bus_sel_o,
    output ising_pkg::spin_idx_t bus_s_addr_o,
    output ising_pkg::spin_idx_t bus_d_addr_o,
    output ising_pkg::weight_t   bus_wdata_o
);
    logic last_host_q;

    // Host yields only when it won the previous contest
    assign host_gnt_o  = host_req_i & (~sweep_req_i | ~last_host_q);
    assign sweep_gnt_o = sweep_req_i & ~host_gnt_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            last_host_q <= 1'b0;
        end else if (host_gnt_o) begin
            last_host_q <= 1'b1;
        end else if (sweep_gnt_o) begin
            last_host_q <= 1'b0;
        end
    end

    assign bus_sel_o    = host_gnt_o | sweep_gnt_o;
    assign bus_we_o     = host_gnt_o ? host_we_i     : sweep_we_i;
    assign bus_s_addr_o = host_gnt_o ? host_s_addr_i : sweep_s_addr_i;
    assign bus_d_addr_o = host_gnt_o ? host_d_addr_i : sweep_d_addr_i;
    assign bus_wdata_o  = host_gnt_o ? host_wdata_i  : sweep_wdata_i;

endmodule

// ==== host_port.sv ====
// Four-phase host access port

`timescale 1ns/1ps

module host_port (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 host_req_i,
    input  logic                 host_we_i,
    input  ising_pkg::spin_idx_t host_s_addr_i,
    input  ising_pkg::spin_idx_t host_d_addr_i,
    input  ising_pkg::weight_t   host_wdata_i,
    output logic                 host_ack_o,
    output ising_pkg::weight_t   host_rdata_o,
    output logic                 bus_req_o,
    input  logic                 bus_gnt_i,
    input  ising_pkg::weight_t   bus_rdata_i,
    output logic                 bus_we_o,
    output ising_pkg::spin_idx_t bus_s_addr_o,
    output ising_pkg::spin_idx_t bus_d_addr_o,
    output ising_pkg::weight_t   bus_wdata_o
);
    import ising_pkg::*;

    host_state_t state_q;
    weight_t     rdata_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= H_IDLE;
        end else begin
            case (state_q)
                H_IDLE:     if (host_req_i) state_q <= H_WAIT_GNT;
                H_WAIT_GNT: if (bus_gnt_i) state_q <= H_ACK;
                H_ACK:      if (!host_req_i) state_q <= H_IDLE;
                default:    state_q <= H_IDLE;
            endcase
        end
    end

    // Read data is taken on the single granted cycle
    always_ff @(posedge clk) begin
        if (state_q == H_WAIT_GNT && bus_gnt_i) begin
            rdata_q <= bus_rdata_i;
        end
    end

    assign bus_req_o    = (state_q == H_WAIT_GNT);
    assign bus_we_o     = host_we_i;
    assign bus_s_addr_o = host_s_addr_i;
    assign bus_d_addr_o = host_d_addr_i;
    assign bus_wdata_o  = host_wdata_i;
    assign host_ack_o   = (state_q == H_ACK);
    assign host_rdata_o = rdata_q;

endmodule

// ==== ising_core.f ====
ising_pkg.sv
recursive_matrix.sv
bus_arbiter.sv
host_port.sv
spin_sweeper.sv
ising_core.sv
ising_core_assert.sv
tb_ising_core.sv

// ==== ising_core.sv ====
// Ising machine core top level

`timescale 1ns/1ps

module ising_core (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  host_req_i,
    input  logic                  host_we_i,
    input  ising_pkg::spin_idx_t  host_s_addr_i,
    input  ising_pkg::spin_idx_t  host_d_addr_i,
    input  ising_pkg::weight_t    host_wdata_i,
    output logic                  host_ack_o,
    output ising_pkg::weight_t    host_rdata_o,
    input  logic                  run_req_i,
    input  ising_pkg::spin_vec_t  init_spins_i,
    input  ising_pkg::sweep_cnt_t sweeps_i,
    output logic                  run_ack_o,
    output ising_pkg::spin_vec_t  spins_o
);
    import ising_pkg::*;

    logic      host_req;
    logic      host_gnt;
    logic      host_we;
    spin_idx_t host_s;
    spin_idx_t host_d;
    weight_t   host_wdata;
    logic      sweep_req;
    logic      sweep_gnt;
    spin_idx_t sweep_s;
    spin_idx_t sweep_d;
    logic      bus_we;
    logic      bus_sel;
    spin_idx_t bus_s;
    spin_idx_t bus_d;
    weight_t   bus_wdata;
    weight_t   bus_rdata;

    host_port i_host (
        .clk(clk), .rst_i(rst_i),
        .host_req_i(host_req_i), .host_we_i(host_we_i),
        .host_s_addr_i(host_s_addr_i), .host_d_addr_i(host_d_addr_i),
        .host_wdata_i(host_wdata_i), .host_ack_o(host_ack_o), .host_rdata_o(host_rdata_o),
        .bus_req_o(host_req), .bus_gnt_i(host_gnt), .bus_rdata_i(bus_rdata),
        .bus_we_o(host_we), .bus_s_addr_o(host_s), .bus_d_addr_o(host_d),
        .bus_wdata_o(host_wdata)
    );

    spin_sweeper i_sweeper (
        .clk(clk), .rst_i(rst_i),
        .run_req_i(run_req_i), .init_spins_i(init_spins_i), .sweeps_i(sweeps_i),
        .run_ack_o(run_ack_o), .spins_o(spins_o),
        .bus_req_o(sweep_req), .bus_gnt_i(sweep_gnt),
        .bus_s_addr_o(sweep_s), .bus_d_addr_o(sweep_d), .bus_rdata_i(bus_rdata)
    );

    // The sweeper only reads
    bus_arbiter i_arbiter (
        .clk(clk), .rst_i(rst_i),
        .host_req_i(host_req), .host_we_i(host_we), .host_s_addr_i(host_s),
        .host_d_addr_i(host_d), .host_wdata_i(host_wdata),
        .sweep_req_i(sweep_req), .sweep_we_i(1'b0), .sweep_s_addr_i(sweep_s),
        .sweep_d_addr_i(sweep_d), .sweep_wdata_i('0),
        .host_gnt_o(host_gnt), .sweep_gnt_o(sweep_gnt),
        .bus_we_o(bus_we), .bus_sel_o(bus_sel), .bus_s_addr_o(bus_s),
        .bus_d_addr_o(bus_d), .bus_wdata_o(bus_wdata)
    );

    recursive_matrix #(.N(NUM_SPINS), .DIAGONAL(1)) i_matrix (
        .clk(clk), .rst_i(rst_i),
        .wr_en_i(bus_we), .sel_i(bus_sel),
        .s_addr_i(bus_s), .d_addr_i(bus_d),
        .wdata_i(bus_wdata), .rdata_o(bus_rdata)
    );

endmodule

// ==== ising_core_assert.sv ====
// Ising core handshake and grant checks

`timescale 1ns/1ps

module ising_core_assert (
    input logic clk,
    input logic rst_i,
    input logic host_req_i,
    input logic host_ack_i,
    input logic run_req_i,
    input logic run_ack_i,
    input logic host_bus_req_i,
    input logic sweep_bus_req_i,
    input logic host_gnt_i,
    input logic sweep_gnt_i
);

    // Acks may only rise in answer to a request
    a_host_ack_rise: assert property (@(posedge clk) disable iff (rst_i)
        !host_req_i && !host_ack_i |=> !host_ack_i)
        else $error("host ack rose without a request");

    a_run_ack_rise: assert property (@(posedge clk) disable iff (rst_i)
        !run_req_i && !run_ack_i |=> !run_ack_i)
        else $error("run ack rose without a request");

    // Ack stays up while the request is held
    a_host_ack_hold: assert property (@(posedge clk) disable iff (rst_i)
        host_ack_i && host_req_i |=> host_ack_i)
        else $error("host ack dropped while the request was high");

    a_run_ack_hold: assert property (@(posedge clk) disable iff (rst_i)
        run_ack_i && run_req_i |=> run_ack_i)
        else $error("run ack dropped while the request was high");

    // Round robin serves a waiting master on the next cycle
    a_host_wait: assert property (@(posedge clk) disable iff (rst_i)
        host_bus_req_i && !host_gnt_i |=> host_gnt_i)
        else $error("host bus request waited more than one cycle");

    a_sweep_wait: assert property (@(posedge clk) disable iff (rst_i)
        sweep_bus_req_i && !sweep_gnt_i |=> sweep_gnt_i)
        else $error("sweeper bus request waited more than one cycle");

endmodule

bind ising_core ising_core_assert i_assert (
    .clk             (clk),
    .rst_i           (rst_i),
    .host_req_i      (host_req_i),
    .host_ack_i      (host_ack_o),
    .run_req_i       (run_req_i),
    .run_ack_i       (run_ack_o),
    .host_bus_req_i  (host_req),
    .sweep_bus_req_i (sweep_req),
    .host_gnt_i      (host_gnt),
    .sweep_gnt_i     (sweep_gnt)
);

// ==== ising_pkg.sv ====
// Ising core shared definitions

package ising_pkg;

    localparam int NUM_SPINS = 8;
    localparam int ADDR_W    = 3;
    localparam int WEIGHT_W  = 8;
    // Eight signed 8-bit terms fit without overflow
    localparam int FIELD_W   = 12;
    localparam int SWEEP_W   = 8;

    typedef logic [ADDR_W-1:0] spin_idx_t;

    // Two's complement coupling or bias
    typedef logic [WEIGHT_W-1:0] weight_t;

    typedef logic signed [FIELD_W-1:0] field_t;

    // Bit set means spin +1, clear means spin -1
    typedef logic [NUM_SPINS-1:0] spin_vec_t;

    typedef logic [SWEEP_W-1:0] sweep_cnt_t;

    typedef enum logic [1:0] {
        H_IDLE,
        H_WAIT_GNT,
        H_ACK
    } host_state_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ACCUM,
        S_UPDATE,
        S_DONE
    } sweep_state_t;

endpackage

// ==== recursive_matrix.sv ====
// Recursive quadtree weight store
// Symmetric fold on the diagonal

`timescale 1ns/1ps

module recursive_matrix #(
    parameter int N        = 8,
    parameter bit DIAGONAL = 1
) (
    input  logic                                 clk,
    input  logic                                 rst_i,
    input  logic                                 wr_en_i,
    input  logic                                 sel_i,
    input  logic [((N > 1) ? $clog2(N) : 1)-1:0] s_addr_i,
    input  logic [((N > 1) ? $clog2(N) : 1)-1:0] d_addr_i,
    input  ising_pkg::weight_t                   wdata_i,
    output ising_pkg::weight_t                   rdata_o
);
    import ising_pkg::*;

    if (N > 1) begin : g_split
        localparam int TOP = $clog2(N) - 1;
        localparam int CW  = (N > 2) ? TOP : 1;

        logic          s_hi;
        logic          d_hi;
        logic          tl;
        logic          tr;
        logic          bl;
        logic          br;
        logic [CW-1:0] s_lo;
        logic [CW-1:0] d_lo;
        logic [CW-1:0] tr_s;
        logic [CW-1:0] tr_d;
        logic          tr_sel;
        weight_t       tl_r;
        weight_t       tr_r;
        weight_t       br_r;

        // Top address bits pick the quadrant
        assign s_hi = s_addr_i[TOP];
        assign d_hi = d_addr_i[TOP];
        assign tl   = ~s_hi & ~d_hi;
        assign br   =  s_hi &  d_hi;
        assign tr   =  s_hi & ~d_hi;
        assign bl   = ~s_hi &  d_hi;

        // Children of size 1 ignore their address
        if (N > 2) begin : g_lo
            assign s_lo = s_addr_i[CW-1:0];
            assign d_lo = d_addr_i[CW-1:0];
        end else begin : g_lo
            assign s_lo = 1'b0;
            assign d_lo = 1'b0;
        end

        if (DIAGONAL) begin : g_fold
            // Transposed access lands in the top-right child
            assign tr_s    = bl ? d_lo : s_lo;
            assign tr_d    = bl ? s_lo : d_lo;
            assign tr_sel  = sel_i & (tr | bl);
            assign rdata_o = tl ? tl_r : (br ? br_r : tr_r);
        end else begin : g_full
            weight_t bl_r;

            assign tr_s   = s_lo;
            assign tr_d   = d_lo;
            assign tr_sel = sel_i & tr;

            recursive_matrix #(.N(N/2), .DIAGONAL(0)) bot_left (
                .clk      (clk),
                .rst_i    (rst_i),
                .wr_en_i  (wr_en_i),
                .sel_i    (sel_i & bl),
                .s_addr_i (s_lo),
                .d_addr_i (d_lo),
                .wdata_i  (wdata_i),
                .rdata_o  (bl_r)
            );

            always_comb begin
                case ({s_hi, d_hi})
                    2'b00:   rdata_o = tl_r;
                    2'b10:   rdata_o = tr_r;
                    2'b01:   rdata_o = bl_r;
                    default: rdata_o = br_r;
                endcase
            end
        end

        recursive_matrix #(.N(N/2), .DIAGONAL(DIAGONAL)) top_left (
            .clk      (clk),
            .rst_i    (rst_i),
            .wr_en_i  (wr_en_i),
            .sel_i    (sel_i & tl),
            .s_addr_i (s_lo),
            .d_addr_i (d_lo),
            .wdata_i  (wdata_i),
            .rdata_o  (tl_r)
        );

        recursive_matrix #(.N(N/2), .DIAGONAL(0)) top_right (
            .clk      (clk),
            .rst_i    (rst_i),
            .wr_en_i  (wr_en_i),
            .sel_i    (tr_sel),
            .s_addr_i (tr_s),
            .d_addr_i (tr_d),
            .wdata_i  (wdata_i),
            .rdata_o  (tr_r)
        );

        recursive_matrix #(.N(N/2), .DIAGONAL(DIAGONAL)) bot_right (
            .clk      (clk),
            .rst_i    (rst_i),
            .wr_en_i  (wr_en_i),
            .sel_i    (sel_i & br),
            .s_addr_i (s_lo),
            .d_addr_i (d_lo),
            .wdata_i  (wdata_i),
            .rdata_o  (br_r)
        );
    end else begin : g_cell
        // Holds a bias on the diagonal, a coupling elsewhere
        weight_t w_q;

        always_ff @(posedge clk) begin
            if (rst_i) begin
                w_q <= '0;
            end else if (sel_i && wr_en_i) begin
                w_q <= wdata_i;
            end
        end

        assign rdata_o = w_q;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the Ising core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ising_core -f ising_core.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_ising_core)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

// ==== spin_sweeper.sv ====
// Zero-temperature sequential spin sweeper

`timescale 1ns/1ps

module spin_sweeper (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   run_req_i,
    input  ising_pkg::spin_vec_t   init_spins_i,
    input  ising_pkg::sweep_cnt_t  sweeps_i,
    output logic                   run_ack_o,
    output ising_pkg::spin_vec_t   spins_o,
    output logic                   bus_req_o,
    input  logic                   bus_gnt_i,
    output ising_pkg::spin_idx_t   bus_s_addr_o,
    output ising_pkg::spin_idx_t   bus_d_addr_o,
    input  ising_pkg::weight_t     bus_rdata_i
);
    import ising_pkg::*;

    sweep_state_t state_q;
    spin_vec_t    spins_q;
    spin_idx_t    spin_i_q;
    spin_idx_t    col_j_q;
    field_t       field_q;
    sweep_cnt_t   sweeps_left_q;
    field_t       w_ext;
    field_t       term;

    assign w_ext = {{(FIELD_W-WEIGHT_W){bus_rdata_i[WEIGHT_W-1]}}, bus_rdata_i};

    // Bias adds as is, couplings take the sign of spin j
    always_comb begin
        if (col_j_q == spin_i_q || spins_q[col_j_q]) begin
            term = w_ext;
        end else begin
            term = -w_ext;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q       <= S_IDLE;
            spins_q       <= '0;
            spin_i_q      <= '0;
            col_j_q       <= '0;
            field_q       <= '0;
            sweeps_left_q <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (run_req_i) begin
                        spins_q       <= init_spins_i;
                        sweeps_left_q <= sweeps_i;
                        spin_i_q      <= '0;
                        col_j_q       <= '0;
                        field_q       <= '0;
                        state_q       <= (sweeps_i == '0) ? S_DONE : S_ACCUM;
                    end
                end
                S_ACCUM: begin
                    if (bus_gnt_i) begin
                        field_q <= field_q + term;
                        col_j_q <= col_j_q + 1'b1;
                        if (col_j_q == spin_idx_t'(NUM_SPINS - 1)) state_q <= S_UPDATE;
                    end
                end
                S_UPDATE: begin
                    // A zero field leaves the spin alone
                    if (field_q > 0) begin
                        spins_q[spin_i_q] <= 1'b1;
                    end else if (field_q < 0) begin
                        spins_q[spin_i_q] <= 1'b0;
                    end
                    field_q  <= '0;
                    spin_i_q <= spin_i_q + 1'b1;
                    state_q  <= S_ACCUM;
                    if (spin_i_q == spin_idx_t'(NUM_SPINS - 1)) begin
                        sweeps_left_q <= sweeps_left_q - 1'b1;
                        if (sweeps_left_q == sweep_cnt_t'(1)) state_q <= S_DONE;
                    end
                end
                S_DONE:  if (!run_req_i) state_q <= S_IDLE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    assign bus_req_o    = (state_q == S_ACCUM);
    assign bus_s_addr_o = spin_i_q;
    assign bus_d_addr_o = col_j_q;
    assign run_ack_o    = (state_q == S_DONE);
    assign spins_o      = spins_q;

endmodule

// ==== tb_ising_core.sv ====
// Ising core directed testbench

`timescale 1ns/1ps

module tb_ising_core;
    import ising_pkg::*;

    // Up to 6 tests x 4 sweeps x 8 spins x (8 reads + 1) x 2 for contention plus handshakes
    localparam int TIMEOUT_CYCLES = 20000;

    logic       clk;
    logic       rst_i;
    logic       host_req;
    logic       host_we;
    spin_idx_t  host_s;
    spin_idx_t  host_d;
    weight_t    host_wdata;
    logic       host_ack;
    weight_t    host_rdata;
    logic       run_req;
    spin_vec_t  init_spins;
    sweep_cnt_t sweeps;
    logic       run_ack;
    spin_vec_t  spins;

    // Symmetric shadow of the weight store
    weight_t     shadow [NUM_SPINS][NUM_SPINS];
    logic [31:0] seed;
    int          cycle_cnt = 0;
    int          check_cnt;
    int          err_cnt;
    int          test_cnt;

    ising_core i_dut (
        .clk           (clk),
        .rst_i         (rst_i),
        .host_req_i    (host_req),
        .host_we_i     (host_we),
        .host_s_addr_i (host_s),
        .host_d_addr_i (host_d),
        .host_wdata_i  (host_wdata),
        .host_ack_o    (host_ack),
        .host_rdata_o  (host_rdata),
        .run_req_i     (run_req),
        .init_spins_i  (init_spins),
        .sweeps_i      (sweeps),
        .run_ack_o     (run_ack),
        .spins_o       (spins)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Zero-temperature sequential sweeps over the shadow weights
    function automatic spin_vec_t model_sweeps(input spin_vec_t init, input int n);
        spin_vec_t sp;
        int        k;
        int        i;
        int        j;
        int        f;
        int        w;
        sp = init;
        for (k = 0; k < n; k++) begin
            for (i = 0; i < NUM_SPINS; i++) begin
                f = 0;
                for (j = 0; j < NUM_SPINS; j++) begin
                    w = $signed(shadow[i][j]);
                    if (j == i || sp[j]) f += w;
                    else f -= w;
                end
                if (f > 0) sp[i] = 1'b1;
                else if (f < 0) sp[i] = 1'b0;
            end
        end
        return sp;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_weight(input string name, input weight_t exp, input weight_t act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("[FAIL] %s: expected %02h, got %02h", name, exp, act);
        end
    endtask

    task automatic check_spins(input string name, input spin_vec_t exp, input spin_vec_t act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("[FAIL] %s: expected %08b, got %08b", name, exp, act);
        end
    endtask

    task automatic host_access(input logic we, input spin_idx_t s, input spin_idx_t d,
                               input weight_t wdata, output weight_t rdata);
        host_req   = 1'b1;
        host_we    = we;
        host_s     = s;
        host_d     = d;
        host_wdata = wdata;
        next_cycle();
        while (!host_ack) next_cycle();
        rdata    = host_rdata;
        host_req = 1'b0;
        next_cycle();
        while (host_ack) next_cycle();
    endtask

    task automatic host_write(input spin_idx_t s, input spin_idx_t d, input weight_t w);
        weight_t rd_ignored;
        if (run_req || run_ack) begin
            err_cnt++;
            $display("A weight write was issued while a run was active");
        end
        host_access(1'b1, s, d, w, rd_ignored);
        shadow[s][d] = w;
        shadow[d][s] = w;
    endtask

    task automatic host_read(input spin_idx_t s, input spin_idx_t d, output weight_t w);
        host_access(1'b0, s, d, 8'h00, w);
    endtask

    task automatic check_read(input string name, input spin_idx_t s, input spin_idx_t d);
        weight_t w;
        host_read(s, d, w);
        check_weight(name, shadow[s][d], w);
    endtask

    task automatic start_run(input spin_vec_t init, input sweep_cnt_t n);
        run_req    = 1'b1;
        init_spins = init;
        sweeps     = n;
    endtask

    task automatic finish_run(output spin_vec_t result);
        while (!run_ack) next_cycle();
        result  = spins;
        run_req = 1'b0;
        next_cycle();
        while (run_ack) next_cycle();
    endtask

    task automatic run_sweeps(input spin_vec_t init, input sweep_cnt_t n,
                              output spin_vec_t result);
        start_run(init, n);
        next_cycle();
        finish_run(result);
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, err_cnt - errs_before);
    endtask

    task automatic test_reset();
        int e;
        e = err_cnt;
        if (host_ack !== 1'b0 || run_ack !== 1'b0) begin
            err_cnt++;
            $display("An ack is high after reset");
        end
        check_spins("reset", 8'h00, spins);
        check_read("reset", 3'd0, 3'd0);
        check_read("reset", 3'd2, 3'd5);
        check_read("reset", 3'd7, 3'd3);
        check_read("reset", 3'd6, 3'd6);
        report_test("reset", e);
    endtask

    task automatic test_symmetry();
        int e;
        e = err_cnt;
        host_write(3'd2, 3'd5, 8'h3c);
        check_read("symmetry", 3'd5, 3'd2);
        host_write(3'd6, 3'd1, 8'hc5);
        check_read("symmetry", 3'd1, 3'd6);
        host_write(3'd5, 3'd2, 8'h7e);
        check_read("symmetry", 3'd2, 3'd5);
        check_read("symmetry", 3'd6, 3'd1);
        check_read("symmetry", 3'd0, 3'd7);
        report_test("symmetry", e);
    endtask

    task automatic test_bias();
        int e;
        int i;
        e = err_cnt;
        for (i = 0; i < NUM_SPINS; i++) begin
            host_write(spin_idx_t'(i), spin_idx_t'(i), weight_t'(32'h90 + 11 * i));
        end
        for (i = 0; i < NUM_SPINS; i++) check_read("bias", spin_idx_t'(i), spin_idx_t'(i));
        check_read("bias", 3'd2, 3'd5);
        check_read("bias", 3'd6, 3'd1);
        report_test("bias", e);
    endtask

    task automatic test_ferromagnet();
        int        e;
        int        s;
        int        d;
        spin_vec_t got;
        e = err_cnt;
        for (s = 0; s < NUM_SPINS; s++) begin
            for (d = s; d < NUM_SPINS; d++) begin
                host_write(spin_idx_t'(s), spin_idx_t'(d), (s == d) ? 8'h00 : 8'h01);
            end
        end
        run_sweeps(8'b1110_0001, 8'd1, got);
        check_spins("ferromagnet", model_sweeps(8'b1110_0001, 1), got);
        run_sweeps(8'b1110_0001, 8'd0, got);
        check_spins("ferromagnet", 8'b1110_0001, got);
        report_test("ferromagnet", e);
    endtask

    task automatic test_random();
        int        e;
        int        s;
        int        d;
        spin_vec_t init;
        spin_vec_t got;
        e = err_cnt;
        for (s = 0; s < NUM_SPINS; s++) begin
            for (d = s; d < NUM_SPINS; d++) begin
                host_write(spin_idx_t'(s), spin_idx_t'(d), weight_t'(next_random() >> 24));
            end
        end
        init = spin_vec_t'(next_random() >> 16);
        run_sweeps(init, 8'd1, got);
        check_spins("random", model_sweeps(init, 1), got);
        init = spin_vec_t'(next_random() >> 16);
        run_sweeps(init, 8'd3, got);
        check_spins("random", model_sweeps(init, 3), got);
        report_test("random", e);
    endtask

    task automatic test_contention();
        int        e;
        int        reads;
        spin_idx_t s;
        spin_idx_t d;
        spin_vec_t init;
        spin_vec_t got;
        e     = err_cnt;
        reads = 0;
        init  = spin_vec_t'(next_random() >> 16);
        start_run(init, 8'd4);
        while (!run_ack) begin
            s = spin_idx_t'(next_random() >> 24);
            d = spin_idx_t'(next_random() >> 24);
            check_read("contention", s, d);
            reads++;
        end
        finish_run(got);
        check_spins("contention", model_sweeps(init, 4), got);
        // A second read only starts if the run outlasted the first one
        if (reads < 2) begin
            err_cnt++;
            $display("The run finished within the first host read");
        end
        report_test("contention", e);
    endtask

    initial begin
        int i;
        int j;
        clk        = 1'b0;
        rst_i      = 1'b1;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_s     = '0;
        host_d     = '0;
        host_wdata = '0;
        run_req    = 1'b0;
        init_spins = '0;
        sweeps     = '0;
        seed       = 32'hb4b55fc2;
        check_cnt  = 0;
        err_cnt    = 0;
        test_cnt   = 0;
        for (i = 0; i < NUM_SPINS; i++) begin
            for (j = 0; j < NUM_SPINS; j++) shadow[i][j] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst_i = 1'b0;
        test_reset();
        test_symmetry();
        test_bias();
        test_ferromagnet();
        test_random();
        test_contention();
        $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
